// ==== gbc_mem_pkg.sv ====
package gbc_mem_pkg;

   // bus widths
   localparam int addr_w     = 16;
   localparam int data_w     = 8;
   // eight banks of 4 KB in one RAM
   localparam int ram_addr_w = 15;

   // working ram windows
   localparam logic [addr_w-1:0] wram_fixed_base  = 16'hc000;
   localparam logic [addr_w-1:0] wram_banked_base = 16'hd000;
   localparam logic [addr_w-1:0] wram_end         = 16'hdfff;

   // bank select register
   localparam logic [addr_w-1:0] svbk_addr = 16'hff70;

   // dma control registers, high bytes and start/status
   localparam logic [addr_w-1:0] dma_src_addr = 16'hff51;
   localparam logic [addr_w-1:0] dma_dst_addr = 16'hff52;
   localparam logic [addr_w-1:0] dma_ctl_addr = 16'hff55;

   // bytes moved per dma block
   localparam int block_bytes = 16;

   // value seen on reads that hit nothing
   localparam logic [data_w-1:0] open_bus_data = 8'hff;

   // slave picked by the router
   typedef enum logic [1:0] {
      sel_wram,
      sel_svbk,
      sel_dma,
      sel_none
   } slave_sel_t;

   // dma engine states, each bus cycle followed by a gap
   typedef enum logic [2:0] {
      dma_idle,
      dma_read,
      dma_gap_r,
      dma_write,
      dma_gap_w
   } dma_state_t;

endpackage

// ==== wram_bram.sv ====
`timescale 1ns/1ns

module wram_bram (
   input  logic                                clk,
   input  logic                                en,
   input  logic                                we,
   input  logic [gbc_mem_pkg::ram_addr_w-1:0]  addr,
   input  logic [gbc_mem_pkg::data_w-1:0]      din,
   output logic [gbc_mem_pkg::data_w-1:0]      dout
);

   import gbc_mem_pkg::*;

   // 32 KB, one byte per word
   logic [data_w-1:0] mem [0:(1 << ram_addr_w) - 1];

   // read before write, data out one cycle after en
   always_ff @(posedge clk) begin
      if (en) begin
         if (we) begin
            mem[addr] <= din;
         end
         dout <= mem[addr];
      end
   end

   // address comes from the bank logic upstream
   a_addr_known: assert property (@(posedge clk)
      en |-> !$isunknown(addr));

endmodule

// ==== wb_arbiter.sv ====
`timescale 1ns/1ns

module wb_arbiter (
   input  logic                            clk,
   input  logic                            rst_n,
   // cpu master
   input  logic                            m0_cyc,
   input  logic                            m0_stb,
   input  logic                            m0_we,
   input  logic [gbc_mem_pkg::addr_w-1:0]  m0_adr,
   input  logic [gbc_mem_pkg::data_w-1:0]  m0_dat_w,
   output logic [gbc_mem_pkg::data_w-1:0]  m0_dat_r,
   output logic                            m0_ack,
   // dma master
   input  logic                            m1_cyc,
   input  logic                            m1_stb,
   input  logic                            m1_we,
   input  logic [gbc_mem_pkg::addr_w-1:0]  m1_adr,
   input  logic [gbc_mem_pkg::data_w-1:0]  m1_dat_w,
   output logic [gbc_mem_pkg::data_w-1:0]  m1_dat_r,
   output logic                            m1_ack,
   // shared bus
   output logic                            bus_cyc,
   output logic                            bus_stb,
   output logic                            bus_we,
   output logic [gbc_mem_pkg::addr_w-1:0]  bus_adr,
   output logic [gbc_mem_pkg::data_w-1:0]  bus_dat_w,
   input  logic [gbc_mem_pkg::data_w-1:0]  bus_dat_r,
   input  logic                            bus_ack
);

   // one-hot, bit 1 is the dma
   logic [1:0] req;
   logic [1:0] gnt;
   logic [1:0] gnt_q;
   // set when the dma had the bus last
   logic       last_q;

   assign req = {m1_cyc, m0_cyc};

   // owner keeps the bus while its cyc stays up
   // otherwise pick the one not served last
   always_comb begin
      if (|(gnt_q & req)) begin
         gnt = gnt_q;
      end else if (&req) begin
         gnt = last_q ? 2'b01 : 2'b10;
      end else begin
         gnt = req;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gnt_q  <= 2'b00;
         last_q <= 1'b0;
      end else begin
         gnt_q <= gnt;
         if (|gnt) begin
            last_q <= gnt[1];
         end
      end
   end

   // forward the granted master
   assign bus_cyc   = |(gnt & req);
   assign bus_stb   = gnt[1] ? m1_stb : (gnt[0] & m0_stb);
   assign bus_we    = gnt[1] ? m1_we : m0_we;
   assign bus_adr   = gnt[1] ? m1_adr : m0_adr;
   assign bus_dat_w = gnt[1] ? m1_dat_w : m0_dat_w;

   // the loser sees no ack and keeps waiting
   assign m0_dat_r = bus_dat_r;
   assign m1_dat_r = bus_dat_r;
   assign m0_ack   = gnt[0] & bus_ack;
   assign m1_ack   = gnt[1] & bus_ack;

   // strobe only from a master that is really requesting
   a_gnt_has_cyc: assert property (@(posedge clk) disable iff (!rst_n)
      bus_stb |-> (gnt[0] && m0_cyc) || (gnt[1] && m1_cyc));

   // an ack returns to whoever held the bus when it was strobed
   a_ack_m0: assert property (@(posedge clk) disable iff (!rst_n)
      m0_ack |-> $past(gnt[0]));
   a_ack_m1: assert property (@(posedge clk) disable iff (!rst_n)
      m1_ack |-> $past(gnt[1]));

endmodule

// ==== mem_router.sv ====
`timescale 1ns/1ns

module mem_router (
   input  logic                            clk,
   input  logic                            rst_n,
   // shared bus from the arbiter
   input  logic                            bus_cyc,
   input  logic                            bus_stb,
   input  logic [gbc_mem_pkg::addr_w-1:0]  bus_adr,
   output logic [gbc_mem_pkg::data_w-1:0]  bus_dat_r,
   output logic                            bus_ack,
   // per slave strobes
   output logic                            wram_stb,
   output logic                            svbk_stb,
   output logic                            dmareg_stb,
   // slave returns
   input  logic [gbc_mem_pkg::data_w-1:0]  wram_dat_r,
   input  logic                            wram_ack,
   input  logic [gbc_mem_pkg::data_w-1:0]  svbk_dat_r,
   input  logic                            svbk_ack,
   input  logic [gbc_mem_pkg::data_w-1:0]  dmareg_dat_r,
   input  logic                            dmareg_ack
);

   import gbc_mem_pkg::*;

   slave_sel_t sel;
   logic       req;
   logic       none_stb;
   logic       none_ack;

   assign req = bus_cyc & bus_stb;

   // address map
   always_comb begin
      if (bus_adr >= wram_fixed_base && bus_adr <= wram_end) begin
         sel = sel_wram;
      end else if (bus_adr == svbk_addr) begin
         sel = sel_svbk;
      end else if (bus_adr == dma_src_addr || bus_adr == dma_dst_addr ||
                   bus_adr == dma_ctl_addr) begin
         sel = sel_dma;
      end else begin
         sel = sel_none;
      end
   end

   assign wram_stb   = req && sel == sel_wram;
   assign svbk_stb   = req && sel == sel_svbk;
   assign dmareg_stb = req && sel == sel_dma;
   assign none_stb   = req && sel == sel_none;

   // unmapped space still answers, one cycle late like the others
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         none_ack <= 1'b0;
      end else begin
         none_ack <= none_stb && !none_ack;
      end
   end

   // address is held until ack, so the live select picks the return
   always_comb begin
      case (sel)
         sel_wram: begin
            bus_dat_r = wram_dat_r;
            bus_ack   = wram_ack;
         end
         sel_svbk: begin
            bus_dat_r = svbk_dat_r;
            bus_ack   = svbk_ack;
         end
         sel_dma: begin
            bus_dat_r = dmareg_dat_r;
            bus_ack   = dmareg_ack;
         end
         default: begin
            bus_dat_r = open_bus_data;
            bus_ack   = none_ack;
         end
      endcase
   end

   a_one_slave: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({wram_stb, svbk_stb, dmareg_stb}));

   // no slave answers a cycle that was never strobed
   a_ack_follows_stb: assert property (@(posedge clk) disable iff (!rst_n)
      bus_ack |-> $past(req));

endmodule

// ==== working_memory_bank.sv ====
`timescale 1ns/1ns

module working_memory_bank (
   input  logic                            clk,
   input  logic                            rst_n,
   // dmg mode pins the bank to 1
   input  logic                            dmg_mode,
   // shared bus fields
   input  logic                            bus_we,
   input  logic [gbc_mem_pkg::addr_w-1:0]  bus_adr,
   input  logic [gbc_mem_pkg::data_w-1:0]  bus_dat_w,
   // strobes from the router
   input  logic                            wram_stb,
   input  logic                            svbk_stb,
   // returns
   output logic [gbc_mem_pkg::data_w-1:0]  wram_dat_r,
   output logic                            wram_ack,
   output logic [gbc_mem_pkg::data_w-1:0]  svbk_dat_r,
   output logic                            svbk_ack
);

   import gbc_mem_pkg::*;

   // bank select register
   logic [2:0]            svbk;
   // bank actually used for this access
   logic [2:0]            bank;
   logic [ram_addr_w-1:0] ram_addr;
   logic                  bram_en;
   logic                  bram_we;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         svbk     <= 3'd0;
         wram_ack <= 1'b0;
         svbk_ack <= 1'b0;
      end else begin
         // single cycle acks, one cycle after the strobe
         wram_ack <= wram_stb && !wram_ack;
         svbk_ack <= svbk_stb && !svbk_ack;
         // register frozen in dmg mode
         if (svbk_stb && bus_we && !svbk_ack && !dmg_mode) begin
            svbk <= bus_dat_w[2:0];
         end
      end
   end

   // unused upper bits read as ones
   assign svbk_dat_r = {{(data_w - 3){1'b1}}, svbk};

   // 0xc000 window is always bank 0
   // 0xd000 window follows svbk, where 0 means bank 1
   always_comb begin
      if (bus_adr < wram_banked_base) begin
         bank = 3'd0;
      end else if (svbk == 3'd0 || dmg_mode) begin
         bank = 3'd1;
      end else begin
         bank = svbk;
      end
   end

   // bank on top, 4 KB offset below
   assign ram_addr = {bank, bus_adr[11:0]};

   // ram works on the first strobe cycle only
   assign bram_en = wram_stb && !wram_ack;
   assign bram_we = bram_en && bus_we;

   wram_bram banked_memory (
      .clk  (clk),
      .en   (bram_en),
      .we   (bram_we),
      .addr (ram_addr),
      .din  (bus_dat_w),
      .dout (wram_dat_r)
   );

   // bank math only holds for addresses inside the working ram window
   a_stb_in_window: assert property (@(posedge clk) disable iff (!rst_n)
      wram_stb |-> bus_adr >= wram_fixed_base && bus_adr <= wram_end);

endmodule

// ==== block_dma.sv ====
`timescale 1ns/1ns

module block_dma (
   input  logic                            clk,
   input  logic                            rst_n,
   // register slave
   input  logic                            bus_we,
   input  logic [gbc_mem_pkg::addr_w-1:0]  bus_adr,
   input  logic [gbc_mem_pkg::data_w-1:0]  bus_dat_w,
   input  logic                            dmareg_stb,
   output logic [gbc_mem_pkg::data_w-1:0]  dmareg_dat_r,
   output logic                            dmareg_ack,
   // copy master
   output logic                            m_cyc,
   output logic                            m_stb,
   output logic                            m_we,
   output logic [gbc_mem_pkg::addr_w-1:0]  m_adr,
   output logic [gbc_mem_pkg::data_w-1:0]  m_dat_w,
   input  logic [gbc_mem_pkg::data_w-1:0]  m_dat_r,
   input  logic                            m_ack
);

   import gbc_mem_pkg::*;

   localparam int cnt_w = $clog2(block_bytes);

   dma_state_t        state;
   // page numbers written by the cpu
   logic [data_w-1:0] src_hi;
   logic [data_w-1:0] dst_hi;
   // running addresses
   logic [addr_w-1:0] src_adr;
   logic [addr_w-1:0] dst_adr;
   // remaining blocks minus one
   logic [6:0]        blocks_left;
   logic [cnt_w-1:0]  byte_cnt;
   logic [data_w-1:0] data_q;
   logic              reg_wr;
   logic              start;
   logic              block_end;
   logic              last_byte;

   assign reg_wr    = dmareg_stb && bus_we && !dmareg_ack;
   // start while busy is dropped
   assign start     = reg_wr && bus_adr == dma_ctl_addr && state == dma_idle;
   assign block_end = byte_cnt == cnt_w'(block_bytes - 1);
   assign last_byte = block_end && blocks_left == 7'd0;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         src_hi     <= '0;
         dst_hi     <= '0;
         dmareg_ack <= 1'b0;
      end else begin
         dmareg_ack <= dmareg_stb && !dmareg_ack;
         if (reg_wr && bus_adr == dma_src_addr) begin
            src_hi <= bus_dat_w;
         end
         if (reg_wr && bus_adr == dma_dst_addr) begin
            dst_hi <= bus_dat_w;
         end
      end
   end

   // status is 0xff when idle, else bit 7 low and the blocks left
   always_comb begin
      case (bus_adr)
         dma_src_addr: dmareg_dat_r = src_hi;
         dma_dst_addr: dmareg_dat_r = dst_hi;
         default:      dmareg_dat_r = (state == dma_idle) ? 8'hff : {1'b0, blocks_left};
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= dma_idle;
         src_adr     <= '0;
         dst_adr     <= '0;
         blocks_left <= '0;
         byte_cnt    <= '0;
      end else begin
         case (state)
            dma_idle: begin
               // pages start at low byte 0
               if (start) begin
                  src_adr     <= {src_hi, 8'h00};
                  dst_adr     <= {dst_hi, 8'h00};
                  blocks_left <= bus_dat_w[6:0];
                  byte_cnt    <= '0;
                  state       <= dma_read;
               end
            end
            dma_read: begin
               if (m_ack) begin
                  state <= dma_gap_r;
               end
            end
            // cyc low so the cpu can win the bus
            dma_gap_r: state <= dma_write;
            dma_write: begin
               if (m_ack) begin
                  src_adr  <= src_adr + 1'b1;
                  dst_adr  <= dst_adr + 1'b1;
                  byte_cnt <= byte_cnt + 1'b1;
                  if (block_end) begin
                     blocks_left <= blocks_left - 1'b1;
                  end
                  // idle also keeps cyc low
                  state <= last_byte ? dma_idle : dma_gap_w;
               end
            end
            dma_gap_w: state <= dma_read;
            default:   state <= dma_idle;
         endcase
      end
   end

   // byte in flight
   always_ff @(posedge clk) begin
      if (state == dma_read && m_ack) begin
         data_q <= m_dat_r;
      end
   end

   assign m_cyc   = state == dma_read || state == dma_write;
   assign m_stb   = m_cyc;
   assign m_we    = state == dma_write;
   assign m_adr   = m_we ? dst_adr : src_adr;
   assign m_dat_w = data_q;

   a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
      m_stb |-> m_cyc);

   // request held steady until the arbiter lets the ack through
   a_hold_req: assert property (@(posedge clk) disable iff (!rst_n)
      m_stb && !m_ack |=> m_stb && $stable(m_adr) && $stable(m_we));

endmodule

// ==== gbc_wram_top.sv ====
`timescale 1ns/1ns

module gbc_wram_top (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            dmg_mode,
   // cpu wishbone port
   input  logic                            cpu_cyc,
   input  logic                            cpu_stb,
   input  logic                            cpu_we,
   input  logic [gbc_mem_pkg::addr_w-1:0]  cpu_adr,
   input  logic [gbc_mem_pkg::data_w-1:0]  cpu_dat_w,
   output logic [gbc_mem_pkg::data_w-1:0]  cpu_dat_r,
   output logic                            cpu_ack
);

   import gbc_mem_pkg::*;

   // dma master
   logic              dma_m_cyc;
   logic              dma_m_stb;
   logic              dma_m_we;
   logic [addr_w-1:0] dma_m_adr;
   logic [data_w-1:0] dma_m_dat_w;
   logic [data_w-1:0] dma_m_dat_r;
   logic              dma_m_ack;

   // shared bus
   logic              bus_cyc;
   logic              bus_stb;
   logic              bus_we;
   logic [addr_w-1:0] bus_adr;
   logic [data_w-1:0] bus_dat_w;
   logic [data_w-1:0] bus_dat_r;
   logic              bus_ack;

   // slave side
   logic              wram_stb;
   logic              svbk_stb;
   logic              dmareg_stb;
   logic [data_w-1:0] wram_dat_r;
   logic              wram_ack;
   logic [data_w-1:0] svbk_dat_r;
   logic              svbk_ack;
   logic [data_w-1:0] dmareg_dat_r;
   logic              dmareg_ack;

   // cpu is master 0, dma is master 1
   wb_arbiter arbiter (
      .clk       (clk),
      .rst_n     (rst_n),
      .m0_cyc    (cpu_cyc),
      .m0_stb    (cpu_stb),
      .m0_we     (cpu_we),
      .m0_adr    (cpu_adr),
      .m0_dat_w  (cpu_dat_w),
      .m0_dat_r  (cpu_dat_r),
      .m0_ack    (cpu_ack),
      .m1_cyc    (dma_m_cyc),
      .m1_stb    (dma_m_stb),
      .m1_we     (dma_m_we),
      .m1_adr    (dma_m_adr),
      .m1_dat_w  (dma_m_dat_w),
      .m1_dat_r  (dma_m_dat_r),
      .m1_ack    (dma_m_ack),
      .bus_cyc   (bus_cyc),
      .bus_stb   (bus_stb),
      .bus_we    (bus_we),
      .bus_adr   (bus_adr),
      .bus_dat_w (bus_dat_w),
      .bus_dat_r (bus_dat_r),
      .bus_ack   (bus_ack)
   );

   mem_router router (
      .clk          (clk),
      .rst_n        (rst_n),
      .bus_cyc      (bus_cyc),
      .bus_stb      (bus_stb),
      .bus_adr      (bus_adr),
      .bus_dat_r    (bus_dat_r),
      .bus_ack      (bus_ack),
      .wram_stb     (wram_stb),
      .svbk_stb     (svbk_stb),
      .dmareg_stb   (dmareg_stb),
      .wram_dat_r   (wram_dat_r),
      .wram_ack     (wram_ack),
      .svbk_dat_r   (svbk_dat_r),
      .svbk_ack     (svbk_ack),
      .dmareg_dat_r (dmareg_dat_r),
      .dmareg_ack   (dmareg_ack)
   );

   // ram plus svbk
   working_memory_bank wram_bank (
      .clk        (clk),
      .rst_n      (rst_n),
      .dmg_mode   (dmg_mode),
      .bus_we     (bus_we),
      .bus_adr    (bus_adr),
      .bus_dat_w  (bus_dat_w),
      .wram_stb   (wram_stb),
      .svbk_stb   (svbk_stb),
      .wram_dat_r (wram_dat_r),
      .wram_ack   (wram_ack),
      .svbk_dat_r (svbk_dat_r),
      .svbk_ack   (svbk_ack)
   );

   // registers on the shared bus, copies through the arbiter
   block_dma dma (
      .clk          (clk),
      .rst_n        (rst_n),
      .bus_we       (bus_we),
      .bus_adr      (bus_adr),
      .bus_dat_w    (bus_dat_w),
      .dmareg_stb   (dmareg_stb),
      .dmareg_dat_r (dmareg_dat_r),
      .dmareg_ack   (dmareg_ack),
      .m_cyc        (dma_m_cyc),
      .m_stb        (dma_m_stb),
      .m_we         (dma_m_we),
      .m_adr        (dma_m_adr),
      .m_dat_w      (dma_m_dat_w),
      .m_dat_r      (dma_m_dat_r),
      .m_ack        (dma_m_ack)
   );

endmodule

// ==== tb_gbc_wram.sv ====
`timescale 1ns/1ns

module tb_gbc_wram;

   import gbc_mem_pkg::*;

   localparam int n_fixed      = 32;
   localparam int dma_blocks   = 3;
   localparam int dma_bytes    = dma_blocks * block_bytes;
   // generous count of cpu accesses over all tests, polls are covered by the dma term
   localparam int n_accesses   = 3 + 16 + 4 * n_fixed + 34 + 12 + 2 * dma_bytes
                                 + 2 * block_bytes + 8 + 4;
   localparam int limit_cycles = n_accesses * 10 + dma_bytes * 20 + 1000;
   // copy from the fixed bank into the switchable one
   localparam logic [7:0] src_page = 8'hc3;
   localparam logic [7:0] dst_page = 8'hd8;

   logic        clk;
   logic        rst_n;
   logic        dmg_mode;
   logic        cpu_cyc;
   logic        cpu_stb;
   logic        cpu_we;
   logic [15:0] cpu_adr;
   logic [7:0]  cpu_dat_w;
   logic [7:0]  cpu_dat_r;
   logic        cpu_ack;

   // reference ram indexed by physical address
   logic [7:0]  ram_model [logic [14:0]];
   logic [2:0]  svbk_model;
   integer      seed;
   // expected value handed to the compare process
   logic [7:0]  exp_val;
   string       exp_name;
   logic        exp_pending;
   logic [15:0] fixed_addr [n_fixed];

   gbc_wram_top DUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .dmg_mode  (dmg_mode),
      .cpu_cyc   (cpu_cyc),
      .cpu_stb   (cpu_stb),
      .cpu_we    (cpu_we),
      .cpu_adr   (cpu_adr),
      .cpu_dat_w (cpu_dat_w),
      .cpu_dat_r (cpu_dat_r),
      .cpu_ack   (cpu_ack)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      repeat (limit_cycles) @(posedge clk);
      $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
      $display("FAIL: see errors above");
      $fatal(1, "watchdog expired");
   end

   // banking rule: 0xc000 window is bank 0, 0xd000 window uses svbk with 0 read as 1
   function automatic logic [14:0] phys_addr(input logic [15:0] addr, input logic [2:0] svbk,
                                             input logic dmg);
      logic [2:0] bank;
      if (addr < 16'hd000) begin
         bank = 3'd0;
      end else if (svbk == 3'd0 || dmg) begin
         bank = 3'd1;
      end else begin
         bank = svbk;
      end
      return {bank, addr[11:0]};
   endfunction

   function automatic logic [7:0] rand_byte();
      integer r;
      r = $random(seed);
      return r[7:0];
   endfunction

   task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s = %02h, expected %02h", $time, name, got, exp);
         $display("FAIL: see errors above");
         $fatal(1, "value mismatch");
      end
   endtask

   // compares every cpu read that has an expected value queued
   always @(negedge clk) begin
      if (exp_pending && cpu_ack && !cpu_we) begin
         check(exp_name, cpu_dat_r, exp_val);
         exp_pending = 1'b0;
      end
   end

   // ack sampled mid cycle, any number of wait states
   task automatic wait_ack();
      do begin
         @(negedge clk);
      end while (cpu_ack !== 1'b1);
   endtask

   task automatic wb_write(input logic [15:0] addr, input logic [7:0] data);
      @(posedge clk);
      cpu_cyc   <= 1'b1;
      cpu_stb   <= 1'b1;
      cpu_we    <= 1'b1;
      cpu_adr   <= addr;
      cpu_dat_w <= data;
      wait_ack();
      @(posedge clk);
      cpu_cyc <= 1'b0;
      cpu_stb <= 1'b0;
      cpu_we  <= 1'b0;
   endtask

   task automatic wb_read(input logic [15:0] addr, output logic [7:0] data);
      @(posedge clk);
      cpu_cyc <= 1'b1;
      cpu_stb <= 1'b1;
      cpu_we  <= 1'b0;
      cpu_adr <= addr;
      wait_ack();
      data = cpu_dat_r;
      @(posedge clk);
      cpu_cyc <= 1'b0;
      cpu_stb <= 1'b0;
   endtask

   task automatic read_expect(input logic [15:0] addr, input logic [7:0] exp, input string name);
      logic [7:0] unused;
      exp_val     = exp;
      exp_name    = name;
      exp_pending = 1'b1;
      wb_read(addr, unused);
   endtask

   // svbk only moves while dmg mode is off
   task automatic set_svbk(input logic [2:0] bank);
      wb_write(svbk_addr, {5'b00000, bank});
      if (!dmg_mode) begin
         svbk_model = bank;
      end
   endtask

   task automatic write_mem(input logic [15:0] addr, input logic [7:0] data);
      wb_write(addr, data);
      ram_model[phys_addr(addr, svbk_model, dmg_mode)] = data;
   endtask

   task automatic read_mem(input logic [15:0] addr);
      logic [14:0] pa;
      pa = phys_addr(addr, svbk_model, dmg_mode);
      if (!ram_model.exists(pa)) begin
         $display("Error at %0t ns: test reads RAM address %04h that was never written",
                  $time, addr);
         $display("FAIL: see errors above");
         $fatal(1, "bad test sequence");
      end
      read_expect(addr, ram_model[pa], "cpu_dat_r");
   endtask

   initial begin
      logic [7:0]  rd;
      logic [7:0]  rd2;
      logic [7:0]  status;
      logic [15:0] src_base;
      logic [15:0] dst_base;
      seed        = 13;
      svbk_model  = 3'd0;
      exp_pending = 1'b0;
      exp_val     = 8'h00;
      exp_name    = "";
      src_base    = {src_page, 8'h00};
      dst_base    = {dst_page, 8'h00};
      rst_n     <= 1'b0;
      dmg_mode  <= 1'b0;
      cpu_cyc   <= 1'b0;
      cpu_stb   <= 1'b0;
      cpu_we    <= 1'b0;
      cpu_adr   <= 16'h0000;
      cpu_dat_w <= 8'h00;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;

      // state right after reset
      @(negedge clk);
      check("cpu_ack", {7'd0, cpu_ack}, 8'h00);
      read_expect(svbk_addr, 8'hf8, "svbk");
      read_expect(dma_ctl_addr, 8'hff, "dma_status");

      // svbk readback, upper five bits always set
      for (int b = 0; b < 8; b++) begin
         set_svbk(3'(b));
         read_expect(svbk_addr, {5'b11111, 3'(b)}, "svbk");
      end

      // fixed bank ignores svbk on both write and read
      for (int i = 0; i < n_fixed; i++) begin
         rd = rand_byte();
         set_svbk(rd[2:0]);
         rd  = rand_byte();
         rd2 = rand_byte();
         fixed_addr[i] = {4'hc, rd[3:0], rd2};
         write_mem(fixed_addr[i], rand_byte());
      end
      for (int i = 0; i < n_fixed; i++) begin
         rd = rand_byte();
         set_svbk(rd[2:0]);
         read_mem(fixed_addr[i]);
      end

      // one address in every bank, svbk 0 lands on bank 1
      for (int b = 0; b < 8; b++) begin
         set_svbk(3'(b));
         write_mem(16'hd123, 8'h50 + 8'(b));
      end
      for (int b = 0; b < 8; b++) begin
         set_svbk(3'(b));
         read_mem(16'hd123);
      end
      set_svbk(3'd0);
      read_expect(16'hd123, 8'h51, "cpu_dat_r");

      // dmg mode freezes svbk and pins the window to bank 1
      set_svbk(3'd5);
      read_expect(svbk_addr, 8'hfd, "svbk");
      @(posedge clk);
      dmg_mode <= 1'b1;
      set_svbk(3'd3);
      read_expect(svbk_addr, 8'hfd, "svbk");
      write_mem(16'hd456, rand_byte());
      write_mem(16'hd000, rand_byte());
      read_mem(16'hd456);
      @(posedge clk);
      dmg_mode <= 1'b0;
      set_svbk(3'd1);
      read_mem(16'hd456);
      read_mem(16'hd000);

      // dma copy into bank 3
      set_svbk(3'd3);
      for (int i = 0; i < dma_bytes; i++) begin
         write_mem(src_base + 16'(i), rand_byte());
      end
      // guard bytes just past the copy
      for (int i = 0; i < block_bytes; i++) begin
         write_mem(dst_base + 16'(dma_bytes + i), rand_byte());
      end
      wb_write(dma_src_addr, src_page);
      wb_write(dma_dst_addr, dst_page);
      read_expect(dma_src_addr, src_page, "dma_src");
      wb_write(dma_ctl_addr, 8'(dma_blocks - 1));
      // a longer copy requested mid run must be dropped
      wb_write(dma_ctl_addr, 8'h05);
      read_expect(dma_ctl_addr, 8'(dma_blocks - 1), "dma_status");
      do begin
         wb_read(dma_ctl_addr, status);
      end while (status !== 8'hff);
      for (int i = 0; i < dma_bytes; i++) begin
         ram_model[phys_addr(dst_base + 16'(i), svbk_model, 1'b0)] =
            ram_model[phys_addr(src_base + 16'(i), svbk_model, 1'b0)];
      end
      for (int i = 0; i < dma_bytes + block_bytes; i++) begin
         read_mem(dst_base + 16'(i));
      end

      // unmapped space
      read_expect(16'hff00, 8'hff, "open_bus");
      read_expect(16'h8000, 8'hff, "open_bus");
      read_expect(16'hfe00, 8'hff, "open_bus");
      read_expect(16'hff50, 8'hff, "open_bus");

      $display("PASS: all tests");
      $finish;
   end

endmodule

// ==== gbc_wram.f ====
gbc_mem_pkg.sv
wram_bram.sv
wb_arbiter.sv
mem_router.sv
working_memory_bank.sv
block_dma.sv
gbc_wram_top.sv
tb_gbc_wram.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= gbc_wram.f
TB_TOP    ?= tb_gbc_wram
RTL_TOP   ?= gbc_wram_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= PASS: all tests

SIM_BIN = $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: build
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
